// File: hw/dq_consts.svh
`ifndef DQ_CONSTS_SVH
`define DQ_CONSTS_SVH

// Stored word width.
`define DQ_XLEN 32

// Instructions per dispatch group.
`define DQ_ENQ_PORTS 4

// Read and release ports per queue.
`define DQ_RD_PORTS 2
`define DQ_WB_PORTS 2

// Most entries reclaimed from the head per cycle.
`define DQ_CLEAR_WID 4

`define DQ_PC_DEPTH 16
`define DQ_IMM_DEPTH 12

// Covers the deeper of the two queues.
`define DQ_IDX_W 4

`endif

// File: hw/dq_pkg.sv
`default_nettype none

`include "dq_consts.svh"

package dq_pkg;

    // One stored PC or immediate.
    typedef logic [`DQ_XLEN-1:0] dq_data_t;

    // Entry index into either queue.
    typedef logic [`DQ_IDX_W-1:0] dq_idx_t;

    // One extra bit so a full queue can be counted.
    typedef logic [`DQ_IDX_W:0] dq_cnt_t;

endpackage

`default_nettype wire

// File: hw/dq_enq_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "dq_consts.svh"

interface dq_enq_if;
    import dq_pkg::*;

    logic [`DQ_ENQ_PORTS-1:0] enq_req;
    dq_data_t                 enq_data [`DQ_ENQ_PORTS];
    logic [`DQ_ENQ_PORTS-1:0] can_enq;
    dq_idx_t                  enq_idx  [`DQ_ENQ_PORTS];

    modport dispatcher (
        output enq_req,
        output enq_data,
        input  can_enq,
        input  enq_idx
    );

    modport queue (
        input  enq_req,
        input  enq_data,
        output can_enq,
        output enq_idx
    );

endinterface

`default_nettype wire

// File: hw/data_que.sv
`timescale 1ns/1ps
`default_nettype none

`include "dq_consts.svh"

module data_que #(
    parameter int DEPTH     = `DQ_PC_DEPTH,
    parameter int CLEAR_WID = `DQ_CLEAR_WID
) (
    input  wire logic                    clk,
    input  wire logic                    i_arst_n,
    dq_enq_if.queue                      enq,
    input  wire dq_pkg::dq_idx_t         i_rd_idx  [`DQ_RD_PORTS],
    output dq_pkg::dq_data_t             o_rd_data [`DQ_RD_PORTS],
    input  wire logic [`DQ_WB_PORTS-1:0] i_wb_vld,
    input  wire dq_pkg::dq_idx_t         i_wb_idx  [`DQ_WB_PORTS]
);
    import dq_pkg::*;

    dq_data_t         mem [DEPTH];
    logic [DEPTH-1:0] busy;
    dq_idx_t          tail;
    dq_idx_t          head;
    dq_cnt_t          count;
    dq_cnt_t          free_cnt;
    dq_cnt_t          enq_num;
    dq_cnt_t          clear_num;
    dq_idx_t          wr_idx [`DQ_ENQ_PORTS];

    // Index arithmetic modulo the depth.
    function automatic dq_idx_t wrap_add(input dq_idx_t base, input dq_cnt_t off);
        dq_cnt_t sum;
        sum = {1'b0, base} + off;
        if (sum >= dq_cnt_t'(DEPTH)) begin
            sum = sum - dq_cnt_t'(DEPTH);
        end
        return sum[`DQ_IDX_W-1:0];
    endfunction

    assign free_cnt = dq_cnt_t'(DEPTH) - count;

    for (genvar p = 0; p < `DQ_ENQ_PORTS; p++) begin : g_enq_port
        assign enq.can_enq[p] = free_cnt > dq_cnt_t'(p);
        assign wr_idx[p]      = wrap_add(tail, dq_cnt_t'(p));
        assign enq.enq_idx[p] = wr_idx[p];
    end

    // Requests are contiguous, so the popcount is the tail step.
    always_comb begin
        enq_num = '0;
        for (int p = 0; p < `DQ_ENQ_PORTS; p++) begin
            enq_num = enq_num + dq_cnt_t'(enq.enq_req[p]);
        end
    end

    // Run of released, occupied entries starting at the head.
    always_comb begin
        logic    in_run;
        dq_idx_t chk_idx;
        in_run    = 1'b1;
        clear_num = '0;
        for (int k = 0; k < CLEAR_WID; k++) begin
            chk_idx = wrap_add(head, dq_cnt_t'(k));
            in_run  = in_run && (dq_cnt_t'(k) < count) && !busy[chk_idx];
            if (in_run) begin
                clear_num = clear_num + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            tail  <= '0;
            head  <= '0;
            count <= '0;
            busy  <= '0;
        end else begin
            tail  <= wrap_add(tail, enq_num);
            head  <= wrap_add(head, clear_num);
            count <= count + enq_num - clear_num;
            for (int w = 0; w < `DQ_WB_PORTS; w++) begin
                if (i_wb_vld[w]) begin
                    busy[i_wb_idx[w]] <= 1'b0;
                end
            end
            // New entries sit past the tail, never on a released slot.
            for (int p = 0; p < `DQ_ENQ_PORTS; p++) begin
                if (enq.enq_req[p]) begin
                    busy[wr_idx[p]] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < `DQ_ENQ_PORTS; p++) begin
            if (enq.enq_req[p]) begin
                mem[wr_idx[p]] <= enq.enq_data[p];
            end
        end
    end

    // Zero-latency reads.
    for (genvar r = 0; r < `DQ_RD_PORTS; r++) begin : g_rd_port
        assign o_rd_data[r] = mem[i_rd_idx[r]];
    end

endmodule

`default_nettype wire

// File: hw/dq_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

`include "dq_consts.svh"

module dq_dispatch (
    input  wire logic [`DQ_ENQ_PORTS-1:0] i_dis_vld,
    input  wire logic [`DQ_ENQ_PORTS-1:0] i_dis_has_imm,
    input  wire dq_pkg::dq_data_t         i_dis_pc      [`DQ_ENQ_PORTS],
    input  wire dq_pkg::dq_data_t         i_dis_imm     [`DQ_ENQ_PORTS],
    output logic                          o_dis_ready,
    output dq_pkg::dq_idx_t               o_dis_pc_idx  [`DQ_ENQ_PORTS],
    output dq_pkg::dq_idx_t               o_dis_imm_idx [`DQ_ENQ_PORTS],
    dq_enq_if.dispatcher                  pc_enq,
    dq_enq_if.dispatcher                  imm_enq
);
    localparam int RANK_W = $clog2(`DQ_ENQ_PORTS);

    logic [`DQ_ENQ_PORTS-1:0] imm_vld;
    logic [RANK_W-1:0]        imm_rank [`DQ_ENQ_PORTS];
    logic [`DQ_ENQ_PORTS-1:0] imm_ports;
    logic                     pc_fit;
    logic                     imm_fit;
    logic                     fire;

    assign imm_vld = i_dis_vld & i_dis_has_imm;

    // Prefix count of immediates in older slots.
    always_comb begin
        logic [RANK_W:0] acc;
        acc       = '0;
        imm_ports = '0;
        for (int s = 0; s < `DQ_ENQ_PORTS; s++) begin
            imm_rank[s] = acc[RANK_W-1:0];
            if (imm_vld[s]) begin
                imm_ports[acc[RANK_W-1:0]] = 1'b1;
                acc = acc + 1'b1;
            end
        end
    end

    // Every port a slot needs must report room.
    assign pc_fit      = &(pc_enq.can_enq | ~i_dis_vld);
    assign imm_fit     = &(imm_enq.can_enq | ~imm_ports);
    assign o_dis_ready = pc_fit & imm_fit;
    assign fire        = o_dis_ready & (|i_dis_vld);

    assign pc_enq.enq_req  = fire ? i_dis_vld : '0;
    assign imm_enq.enq_req = fire ? imm_ports : '0;

    for (genvar s = 0; s < `DQ_ENQ_PORTS; s++) begin : g_slot
        assign pc_enq.enq_data[s] = i_dis_pc[s];
        assign o_dis_pc_idx[s]    = pc_enq.enq_idx[s];
        assign o_dis_imm_idx[s]   = imm_vld[s] ? imm_enq.enq_idx[imm_rank[s]] : '0;
    end

    // Immediates packed onto the lowest ports.
    always_comb begin
        for (int p = 0; p < `DQ_ENQ_PORTS; p++) begin
            imm_enq.enq_data[p] = '0;
        end
        for (int s = 0; s < `DQ_ENQ_PORTS; s++) begin
            if (imm_vld[s]) begin
                imm_enq.enq_data[imm_rank[s]] = i_dis_imm[s];
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/dq_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "dq_consts.svh"

module dq_top (
    input  wire logic                     clk,
    input  wire logic                     i_arst_n,

    input  wire logic [`DQ_ENQ_PORTS-1:0] i_dis_vld,
    input  wire logic [`DQ_ENQ_PORTS-1:0] i_dis_has_imm,
    input  wire dq_pkg::dq_data_t         i_dis_pc      [`DQ_ENQ_PORTS],
    input  wire dq_pkg::dq_data_t         i_dis_imm     [`DQ_ENQ_PORTS],
    output logic                          o_dis_ready,
    output dq_pkg::dq_idx_t               o_dis_pc_idx  [`DQ_ENQ_PORTS],
    output dq_pkg::dq_idx_t               o_dis_imm_idx [`DQ_ENQ_PORTS],

    input  wire dq_pkg::dq_idx_t          i_pc_rd_idx   [`DQ_RD_PORTS],
    output dq_pkg::dq_data_t              o_pc_rd_data  [`DQ_RD_PORTS],
    input  wire logic [`DQ_WB_PORTS-1:0]  i_pc_wb_vld,
    input  wire dq_pkg::dq_idx_t          i_pc_wb_idx   [`DQ_WB_PORTS],

    input  wire dq_pkg::dq_idx_t          i_imm_rd_idx  [`DQ_RD_PORTS],
    output dq_pkg::dq_data_t              o_imm_rd_data [`DQ_RD_PORTS],
    input  wire logic [`DQ_WB_PORTS-1:0]  i_imm_wb_vld,
    input  wire dq_pkg::dq_idx_t          i_imm_wb_idx  [`DQ_WB_PORTS]
);

    dq_enq_if u_pc_enq_if ();
    dq_enq_if u_imm_enq_if ();

    dq_dispatch u_dispatch (
        .i_dis_vld     (i_dis_vld),
        .i_dis_has_imm (i_dis_has_imm),
        .i_dis_pc      (i_dis_pc),
        .i_dis_imm     (i_dis_imm),
        .o_dis_ready   (o_dis_ready),
        .o_dis_pc_idx  (o_dis_pc_idx),
        .o_dis_imm_idx (o_dis_imm_idx),
        .pc_enq        (u_pc_enq_if.dispatcher),
        .imm_enq       (u_imm_enq_if.dispatcher)
    );

    data_que #(
        .DEPTH     (`DQ_PC_DEPTH),
        .CLEAR_WID (`DQ_CLEAR_WID)
    ) u_pc_que (
        .clk       (clk),
        .i_arst_n  (i_arst_n),
        .enq       (u_pc_enq_if.queue),
        .i_rd_idx  (i_pc_rd_idx),
        .o_rd_data (o_pc_rd_data),
        .i_wb_vld  (i_pc_wb_vld),
        .i_wb_idx  (i_pc_wb_idx)
    );

    data_que #(
        .DEPTH     (`DQ_IMM_DEPTH),
        .CLEAR_WID (`DQ_CLEAR_WID)
    ) u_imm_que (
        .clk       (clk),
        .i_arst_n  (i_arst_n),
        .enq       (u_imm_enq_if.queue),
        .i_rd_idx  (i_imm_rd_idx),
        .o_rd_data (o_imm_rd_data),
        .i_wb_vld  (i_imm_wb_vld),
        .i_wb_idx  (i_imm_wb_idx)
    );

endmodule

`default_nettype wire

// File: bench/dq_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module dq_clock_gen #(
    parameter int HALF_PERIOD = 50
) (
    output logic o_clk,
    output logic o_arst_n
);

    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD) o_clk = ~o_clk;
    end

    // Reset held over three rising edges.
    initial begin
        o_arst_n = 1'b0;
        repeat (3) @(posedge o_clk);
        @(negedge o_clk);
        o_arst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: bench/dq_assertions.sv
`timescale 1ns/1ps
`default_nettype none

`include "dq_consts.svh"

module dq_assertions #(
    parameter int DEPTH = `DQ_PC_DEPTH
) (
    input wire logic                     clk,
    input wire logic                     i_arst_n,
    input wire logic [`DQ_ENQ_PORTS-1:0] i_enq_req,
    input wire logic [`DQ_ENQ_PORTS-1:0] i_can_enq,
    input wire dq_pkg::dq_cnt_t          i_count
);
    import dq_pkg::*;

    a_req_has_room: assert property (@(posedge clk) disable iff (!i_arst_n)
        (i_enq_req & ~i_can_enq) == '0)
        else $error("enqueue request raised on a port without room");

    a_count_in_range: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_count <= dq_cnt_t'(DEPTH))
        else $error("occupancy count above the queue depth");

    // A request on port p needs one on port p-1.
    a_req_contiguous: assert property (@(posedge clk) disable iff (!i_arst_n)
        ((i_enq_req >> 1) & ~i_enq_req) == '0)
        else $error("enqueue requests not contiguous from port 0");

endmodule

`default_nettype wire

// File: bench/dq_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "dq_consts.svh"

module dq_tb;
    import dq_pkg::*;

    localparam int P           = `DQ_ENQ_PORTS;
    localparam int RD          = `DQ_RD_PORTS;
    localparam int WB          = `DQ_WB_PORTS;
    localparam int MAX_CYCLES  = 2000;
    localparam int WAIT_LIMIT  = 16;
    localparam int HOLD_CYCLES = 4;

    logic           clk;
    logic           arst_n;
    logic [P-1:0]   dis_vld;
    logic [P-1:0]   dis_has_imm;
    dq_data_t       dis_pc      [P];
    dq_data_t       dis_imm     [P];
    logic           dis_ready;
    dq_idx_t        dis_pc_idx  [P];
    dq_idx_t        dis_imm_idx [P];
    dq_idx_t        pc_rd_idx   [RD];
    dq_data_t       pc_rd_data  [RD];
    logic [WB-1:0]  pc_wb_vld;
    dq_idx_t        pc_wb_idx   [WB];
    dq_idx_t        imm_rd_idx  [RD];
    dq_data_t       imm_rd_data [RD];
    logic [WB-1:0]  imm_wb_vld;
    dq_idx_t        imm_wb_idx  [WB];

    // Reference model with PCs in queue 0 and immediates in queue 1.
    int       depth  [2];
    dq_data_t m_mem  [2][`DQ_PC_DEPTH];
    bit       m_busy [2][`DQ_PC_DEPTH];
    int       m_head [2];
    int       m_tail [2];
    int       m_cnt  [2];

    int seed;
    int cycles;
    int errors;
    int checks;
    int tests_run;
    int tests_failed;

    dq_clock_gen u_clock_gen (
        .o_clk    (clk),
        .o_arst_n (arst_n)
    );

    dq_top dut (
        .clk           (clk),
        .i_arst_n      (arst_n),
        .i_dis_vld     (dis_vld),
        .i_dis_has_imm (dis_has_imm),
        .i_dis_pc      (dis_pc),
        .i_dis_imm     (dis_imm),
        .o_dis_ready   (dis_ready),
        .o_dis_pc_idx  (dis_pc_idx),
        .o_dis_imm_idx (dis_imm_idx),
        .i_pc_rd_idx   (pc_rd_idx),
        .o_pc_rd_data  (pc_rd_data),
        .i_pc_wb_vld   (pc_wb_vld),
        .i_pc_wb_idx   (pc_wb_idx),
        .i_imm_rd_idx  (imm_rd_idx),
        .o_imm_rd_data (imm_rd_data),
        .i_imm_wb_vld  (imm_wb_vld),
        .i_imm_wb_idx  (imm_wb_idx)
    );

    bind data_que dq_assertions #(.DEPTH(DEPTH)) u_assertions (
        .clk       (clk),
        .i_arst_n  (i_arst_n),
        .i_enq_req (enq.enq_req),
        .i_can_enq (enq.can_enq),
        .i_count   (count)
    );

    task automatic check_data(input string name, input dq_data_t got, input dq_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL at %0t: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_idx(input string name, input dq_idx_t got, input dq_idx_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL at %0t: %s got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_ready(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL at %0t: %s got %b, expected %b", $time, name, got, exp);
        end
    endtask

    function automatic int free_of(input int q);
        return depth[q] - m_cnt[q];
    endfunction

    task automatic push_entry(input int q, input dq_data_t data);
        m_mem[q][m_tail[q]]  = data;
        m_busy[q][m_tail[q]] = 1'b1;
        m_tail[q] = (m_tail[q] + 1) % depth[q];
        m_cnt[q]++;
    endtask

    // Final state after the head has swept every released entry.
    task automatic retire_entry(input int q, input int idx);
        m_busy[q][idx] = 1'b0;
        while (m_cnt[q] > 0 && !m_busy[q][m_head[q]]) begin
            m_head[q] = (m_head[q] + 1) % depth[q];
            m_cnt[q]--;
        end
    endtask

    task automatic dispatch_group(input logic [P-1:0] vld, input logic [P-1:0] has_imm,
                                  input int max_wait);
        int waited;
        int rank;
        bit fits;
        @(negedge clk);
        for (int s = 0; s < P; s++) begin
            dis_pc[s]  = $random(seed);
            dis_imm[s] = $random(seed);
        end
        dis_vld     = vld;
        dis_has_imm = has_imm;
        fits = free_of(0) >= $countones(vld) && free_of(1) >= $countones(vld & has_imm);
        #1;
        if (fits) begin
            waited = 0;
            while (dis_ready !== 1'b1 && waited < max_wait) begin
                @(negedge clk);
                #1;
                waited++;
            end
            check_ready("o_dis_ready", dis_ready, 1'b1);
            if (dis_ready === 1'b1) begin
                rank = 0;
                for (int s = 0; s < P; s++) begin
                    if (vld[s]) begin
                        check_idx("o_dis_pc_idx", dis_pc_idx[s],
                                  dq_idx_t'((m_tail[0] + s) % depth[0]));
                        if (has_imm[s]) begin
                            check_idx("o_dis_imm_idx", dis_imm_idx[s],
                                      dq_idx_t'((m_tail[1] + rank) % depth[1]));
                            rank++;
                        end
                    end
                end
                @(posedge clk);
                for (int s = 0; s < P; s++) begin
                    if (vld[s]) begin
                        push_entry(0, dis_pc[s]);
                        if (has_imm[s]) begin
                            push_entry(1, dis_imm[s]);
                        end
                    end
                end
            end
        end else begin
            // Group held while it does not fit.
            for (int c = 0; c < HOLD_CYCLES; c++) begin
                if (c > 0) begin
                    @(negedge clk);
                    #1;
                end
                check_ready("o_dis_ready", dis_ready, 1'b0);
            end
        end
        @(negedge clk);
        dis_vld     = '0;
        dis_has_imm = '0;
    endtask

    task automatic release_range(input int q, input int first, input int n);
        int idx;
        bit wb_on;
        for (int k = 0; k < n; k += WB) begin
            @(negedge clk);
            for (int w = 0; w < WB; w++) begin
                wb_on = (k + w) < n;
                idx   = (first + k + w) % depth[q];
                if (q == 0) begin
                    pc_wb_vld[w] = wb_on;
                    pc_wb_idx[w] = dq_idx_t'(idx);
                end else begin
                    imm_wb_vld[w] = wb_on;
                    imm_wb_idx[w] = dq_idx_t'(idx);
                end
                if (wb_on) begin
                    retire_entry(q, idx);
                end
            end
        end
        @(negedge clk);
        pc_wb_vld  = '0;
        imm_wb_vld = '0;
    endtask

    // Reads every allocated entry of one queue two at a time.
    task automatic read_all(input int q);
        int idx [RD];
        int pos;
        for (int k = 0; k < m_cnt[q]; k += RD) begin
            @(negedge clk);
            for (int r = 0; r < RD; r++) begin
                pos    = (k + r < m_cnt[q]) ? k + r : k;
                idx[r] = (m_head[q] + pos) % depth[q];
                if (q == 0) begin
                    pc_rd_idx[r] = dq_idx_t'(idx[r]);
                end else begin
                    imm_rd_idx[r] = dq_idx_t'(idx[r]);
                end
            end
            #1;
            for (int r = 0; r < RD; r++) begin
                check_data(q == 0 ? "o_pc_rd_data" : "o_imm_rd_data",
                           q == 0 ? pc_rd_data[r] : imm_rd_data[r], m_mem[q][idx[r]]);
            end
        end
    endtask

    task automatic report_test(input string name, input int start_err);
        tests_run++;
        if (errors > start_err) begin
            tests_failed++;
            $display("%s: failed", name);
        end else begin
            $display("%s: passed", name);
        end
    endtask

    task automatic reset_state();
        int start_err;
        start_err = errors;
        dispatch_group(4'b1111, 4'b1111, 0);
        report_test("reset_state", start_err);
    endtask

    task automatic alloc_readback();
        int start_err;
        start_err = errors;
        dispatch_group(4'b1111, 4'b1011, WAIT_LIMIT);
        dispatch_group(4'b0111, 4'b0101, WAIT_LIMIT);
        read_all(0);
        read_all(1);
        report_test("alloc_readback", start_err);
    endtask

    task automatic back_pressure();
        int start_err;
        start_err = errors;
        while (free_of(1) >= 2) begin
            dispatch_group(4'b0011, 4'b0011, WAIT_LIMIT);
        end
        dispatch_group(4'b0011, 4'b0011, WAIT_LIMIT);
        // PC queue still takes a group without immediates.
        dispatch_group(4'b0001, 4'b0000, 0);
        report_test("back_pressure", start_err);
    endtask

    task automatic release_out_of_order();
        int start_err;
        start_err = errors;
        release_range(0, m_head[0] + 1, 1);
        release_range(1, m_head[1] + 1, 1);
        dispatch_group(4'b0011, 4'b0011, WAIT_LIMIT);
        release_range(0, m_head[0], 1);
        release_range(1, m_head[1], 1);
        dispatch_group(4'b0011, 4'b0011, WAIT_LIMIT);
        read_all(1);
        report_test("release_out_of_order", start_err);
    endtask

    task automatic bulk_reclaim();
        int start_err;
        start_err = errors;
        release_range(0, m_head[0], 10);
        release_range(1, m_head[1], 9);
        dispatch_group(4'b1111, 4'b1111, WAIT_LIMIT);
        dispatch_group(4'b1111, 4'b1111, WAIT_LIMIT);
        read_all(0);
        read_all(1);
        report_test("bulk_reclaim", start_err);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Run stopped after %0d cycles without finishing", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        seed         = 8051;
        cycles       = 0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        depth[0]     = `DQ_PC_DEPTH;
        depth[1]     = `DQ_IMM_DEPTH;
        for (int q = 0; q < 2; q++) begin
            m_head[q] = 0;
            m_tail[q] = 0;
            m_cnt[q]  = 0;
            for (int e = 0; e < `DQ_PC_DEPTH; e++) begin
                m_busy[q][e] = 1'b0;
                m_mem[q][e]  = '0;
            end
        end
        dis_vld     = '0;
        dis_has_imm = '0;
        pc_wb_vld   = '0;
        imm_wb_vld  = '0;
        for (int s = 0; s < P; s++) begin
            dis_pc[s]  = '0;
            dis_imm[s] = '0;
        end
        for (int r = 0; r < RD; r++) begin
            pc_rd_idx[r]  = '0;
            imm_rd_idx[r] = '0;
        end
        for (int w = 0; w < WB; w++) begin
            pc_wb_idx[w]  = '0;
            imm_wb_idx[w] = '0;
        end
        wait (arst_n === 1'b1);
        reset_state();
        alloc_readback();
        back_pressure();
        release_out_of_order();
        bulk_reclaim();
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+hw
hw/dq_pkg.sv
hw/dq_enq_if.sv
hw/data_que.sv
hw/dq_dispatch.sv
hw/dq_top.sv
bench/dq_clock_gen.sv
bench/dq_assertions.sv
bench/dq_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
TOP       ?= dq_tb
FILELIST  ?= src.f
OBJDIR    ?= obj_dir
PASS_MSG  := ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
